/* hw/id_settings.svh */
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// datapath and register file sizes
`define REG_W       32
`define REG_NUM     32
`define REG_ADDR_W  5
`define INST_W      32

// instruction fields, used as part selects
`define INST_OP     31:26
`define INST_RS     25:21
`define INST_RT     20:16
`define INST_RD     15:11
`define INST_SHAMT  10:6
`define INST_FUNCT  5:0
`define INST_IMM    15:0

// primary opcodes
`define OP_SPECIAL  6'b000000
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111

// SPECIAL group funct codes
`define FUNCT_SLL   6'b000000
`define FUNCT_SRL   6'b000010
`define FUNCT_SRA   6'b000011
`define FUNCT_SLLV  6'b000100
`define FUNCT_SRLV  6'b000110
`define FUNCT_SRAV  6'b000111
`define FUNCT_MOVZ  6'b001010
`define FUNCT_MOVN  6'b001011
`define FUNCT_ADD   6'b100000
`define FUNCT_ADDU  6'b100001
`define FUNCT_SUB   6'b100010
`define FUNCT_SUBU  6'b100011
`define FUNCT_AND   6'b100100
`define FUNCT_OR    6'b100101
`define FUNCT_XOR   6'b100110
`define FUNCT_NOR   6'b100111
`define FUNCT_SLT   6'b101010
`define FUNCT_SLTU  6'b101011

`endif

/* hw/id_pkg.sv */
`include "id_settings.svh"

package id_pkg;

    // operation handed to the execute stage
    typedef enum logic [4:0] {
        ALU_NOP  = 5'd0,
        ALU_AND  = 5'd1,
        ALU_OR   = 5'd2,
        ALU_XOR  = 5'd3,
        ALU_NOR  = 5'd4,
        ALU_LUI  = 5'd5,
        ALU_SLL  = 5'd6,
        ALU_SRL  = 5'd7,
        ALU_SRA  = 5'd8,
        ALU_ADD  = 5'd9,
        ALU_ADDU = 5'd10,
        ALU_SUB  = 5'd11,
        ALU_SUBU = 5'd12,
        ALU_SLT  = 5'd13,
        ALU_SLTU = 5'd14,
        ALU_MOVN = 5'd15,
        ALU_MOVZ = 5'd16
    } alu_op_e;

    // which result class ex picks
    typedef enum logic [2:0] {
        SEL_NOP   = 3'd0,
        SEL_LOGIC = 3'd1,
        SEL_SHIFT = 3'd2,
        SEL_ARITH = 3'd3,
        SEL_MOVE  = 3'd4
    } alu_sel_e;

    // raw decoder result, before operand fetch
    typedef struct packed {
        alu_op_e                 aluop;
        alu_sel_e                alusel;
        logic                    wreg;
        logic [`REG_ADDR_W-1:0]  waddr;
        logic                    rd1_en;
        logic                    rd2_en;
        logic [`REG_ADDR_W-1:0]  rd1_addr;
        logic [`REG_ADDR_W-1:0]  rd2_addr;
        logic [`REG_W-1:0]       imm;
    } decode_t;

    // contents of the ID/EX pipeline register
    typedef struct packed {
        alu_op_e                 aluop;
        alu_sel_e                alusel;
        logic                    wreg;
        logic [`REG_ADDR_W-1:0]  waddr;
        logic [`REG_W-1:0]       reg1;
        logic [`REG_W-1:0]       reg2;
    } id_ex_t;

    // a register write in flight (ex, mem) or retiring (wb)
    typedef struct packed {
        logic                    wreg;
        logic [`REG_ADDR_W-1:0]  waddr;
        logic [`REG_W-1:0]       wdata;
    } bypass_t;

endpackage

/* hw/inst_decoder.sv */
`timescale 1ns/1ps

`include "id_settings.svh"

module inst_decoder (
    input  logic [`INST_W-1:0] inst_i,
    output id_pkg::decode_t    dec_o
);
    import id_pkg::*;

    logic [5:0]             op;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [4:0]             shamt;
    logic [5:0]             funct;

    logic [`REG_W-1:0] imm_zx;  // andi/ori/xori
    logic [`REG_W-1:0] imm_sx;  // addi/addiu/slti/sltiu
    logic [`REG_W-1:0] imm_hi;  // lui

    alu_op_e           aluop;
    alu_sel_e          alusel;
    logic [`REG_W-1:0] imm;
    logic              i_form;  // rs op imm -> rt
    logic              r_form;  // rs op rt -> rd
    logic              sh_form; // rt shifted by shamt -> rd

    assign op    = inst_i[`INST_OP];
    assign rs    = inst_i[`INST_RS];
    assign rt    = inst_i[`INST_RT];
    assign rd    = inst_i[`INST_RD];
    assign shamt = inst_i[`INST_SHAMT];
    assign funct = inst_i[`INST_FUNCT];

    assign imm_zx = {16'h0000, inst_i[`INST_IMM]};
    assign imm_sx = {{16{inst_i[15]}}, inst_i[`INST_IMM]};
    assign imm_hi = {inst_i[`INST_IMM], 16'h0000};

    always_comb begin
        aluop   = ALU_NOP;  // anything unmatched stays a bubble
        alusel  = SEL_NOP;
        imm     = '0;
        i_form  = 1'b0;
        r_form  = 1'b0;
        sh_form = 1'b0;

        case (op)
            `OP_ANDI: begin
                {aluop, alusel, imm, i_form} = {ALU_AND, SEL_LOGIC, imm_zx, 1'b1};
            end
            `OP_ORI: begin
                {aluop, alusel, imm, i_form} = {ALU_OR, SEL_LOGIC, imm_zx, 1'b1};
            end
            `OP_XORI: begin
                {aluop, alusel, imm, i_form} = {ALU_XOR, SEL_LOGIC, imm_zx, 1'b1};
            end
            `OP_LUI: begin
                {aluop, alusel, imm, i_form} = {ALU_LUI, SEL_LOGIC, imm_hi, 1'b1};
            end
            `OP_ADDI: begin
                {aluop, alusel, imm, i_form} = {ALU_ADD, SEL_ARITH, imm_sx, 1'b1};
            end
            `OP_ADDIU: begin
                {aluop, alusel, imm, i_form} = {ALU_ADDU, SEL_ARITH, imm_sx, 1'b1};
            end
            `OP_SLTI: begin
                {aluop, alusel, imm, i_form} = {ALU_SLT, SEL_ARITH, imm_sx, 1'b1};
            end
            `OP_SLTIU: begin
                {aluop, alusel, imm, i_form} = {ALU_SLTU, SEL_ARITH, imm_sx, 1'b1};
            end
            `OP_SPECIAL: begin
                // register forms need a zero shamt field
                if (shamt == 5'd0) begin
                    r_form = 1'b1;
                    case (funct)
                        `FUNCT_AND:  {aluop, alusel} = {ALU_AND, SEL_LOGIC};
                        `FUNCT_OR:   {aluop, alusel} = {ALU_OR, SEL_LOGIC};
                        `FUNCT_XOR:  {aluop, alusel} = {ALU_XOR, SEL_LOGIC};
                        `FUNCT_NOR:  {aluop, alusel} = {ALU_NOR, SEL_LOGIC};
                        `FUNCT_SLLV: {aluop, alusel} = {ALU_SLL, SEL_SHIFT};
                        `FUNCT_SRLV: {aluop, alusel} = {ALU_SRL, SEL_SHIFT};
                        `FUNCT_SRAV: {aluop, alusel} = {ALU_SRA, SEL_SHIFT};
                        `FUNCT_ADD:  {aluop, alusel} = {ALU_ADD, SEL_ARITH};
                        `FUNCT_ADDU: {aluop, alusel} = {ALU_ADDU, SEL_ARITH};
                        `FUNCT_SUB:  {aluop, alusel} = {ALU_SUB, SEL_ARITH};
                        `FUNCT_SUBU: {aluop, alusel} = {ALU_SUBU, SEL_ARITH};
                        `FUNCT_SLT:  {aluop, alusel} = {ALU_SLT, SEL_ARITH};
                        `FUNCT_SLTU: {aluop, alusel} = {ALU_SLTU, SEL_ARITH};
                        // wreg gated later on the forwarded rt value
                        `FUNCT_MOVN: {aluop, alusel} = {ALU_MOVN, SEL_MOVE};
                        `FUNCT_MOVZ: {aluop, alusel} = {ALU_MOVZ, SEL_MOVE};
                        default:     r_form = 1'b0;
                    endcase
                end
            end
            default: begin
            end
        endcase

        // shift by shamt, only legal with op and rs both zero
        if (op == `OP_SPECIAL && rs == 5'd0) begin
            sh_form = 1'b1;
            imm     = {27'd0, shamt};
            case (funct)
                `FUNCT_SLL: {aluop, alusel} = {ALU_SLL, SEL_SHIFT};
                `FUNCT_SRL: {aluop, alusel} = {ALU_SRL, SEL_SHIFT};
                `FUNCT_SRA: {aluop, alusel} = {ALU_SRA, SEL_SHIFT};
                default: begin
                    sh_form = 1'b0;
                    imm     = '0;
                end
            endcase
        end
    end

    always_comb begin
        dec_o.aluop    = aluop;
        dec_o.alusel   = alusel;
        dec_o.wreg     = i_form | r_form | sh_form;
        dec_o.rd1_en   = i_form | r_form;   // shamt shifts take imm as operand 1
        dec_o.rd2_en   = r_form | sh_form;
        dec_o.rd1_addr = rs;
        dec_o.rd2_addr = rt;
        dec_o.imm      = imm;
        if (i_form) begin
            dec_o.waddr = rt;
        end else if (r_form | sh_form) begin
            dec_o.waddr = rd;
        end else begin
            dec_o.waddr = '0;  // bubble
        end
    end

endmodule

/* hw/operand_bypass.sv */
`timescale 1ns/1ps

`include "id_settings.svh"

module operand_bypass (
    input  logic                   rd_en_i,
    input  logic [`REG_ADDR_W-1:0] rd_addr_i,
    input  logic [`REG_W-1:0]      rf_data_i,
    input  logic [`REG_W-1:0]      imm_i,
    input  id_pkg::bypass_t        ex_fwd_i,
    input  id_pkg::bypass_t        mem_fwd_i,
    output logic [`REG_W-1:0]      operand_o
);

    logic ex_hit;
    logic mem_hit;

    // register zero gets no special treatment here
    assign ex_hit  = ex_fwd_i.wreg && (ex_fwd_i.waddr == rd_addr_i);
    assign mem_hit = mem_fwd_i.wreg && (mem_fwd_i.waddr == rd_addr_i);

    always_comb begin
        if (!rd_en_i) begin
            operand_o = imm_i;
        end else if (ex_hit) begin
            operand_o = ex_fwd_i.wdata;   // youngest write first
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.wdata;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

`include "id_settings.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic [`REG_ADDR_W-1:0] rd1_addr_i,
    input  logic [`REG_ADDR_W-1:0] rd2_addr_i,
    output logic [`REG_W-1:0]      rd1_data_o,
    output logic [`REG_W-1:0]      rd2_data_o,
    input  id_pkg::bypass_t        wb_i
);

    logic [`REG_W-1:0] regs [`REG_NUM];

    // one read port, wb data passes straight through on a same-cycle hit
    function automatic logic [`REG_W-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wb_i.wreg && (wb_i.waddr == addr)) begin
            return wb_i.wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.wreg && (wb_i.waddr != '0)) begin
            regs[wb_i.waddr] <= wb_i.wdata;  // $zero never written
        end
    end

    always_comb begin
        rd1_data_o = read_port(rd1_addr_i);
        rd2_data_o = read_port(rd2_addr_i);
    end

endmodule

/* hw/id_stage.sv */
`timescale 1ns/1ps

`include "id_settings.svh"

module id_stage (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic [`INST_W-1:0] inst_i,
    input  id_pkg::bypass_t    ex_fwd_i,
    input  id_pkg::bypass_t    mem_fwd_i,
    input  id_pkg::bypass_t    wb_i,
    output id_pkg::id_ex_t     id_ex_o
);
    import id_pkg::*;

    decode_t           dec;
    logic [`REG_W-1:0] rf_rd1_data;
    logic [`REG_W-1:0] rf_rd2_data;
    logic [`REG_W-1:0] reg1;
    logic [`REG_W-1:0] reg2;
    logic              wreg;

    inst_decoder u_dec (
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    reg_file u_rf (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rd1_addr_i (dec.rd1_addr),
        .rd2_addr_i (dec.rd2_addr),
        .rd1_data_o (rf_rd1_data),
        .rd2_data_o (rf_rd2_data),
        .wb_i       (wb_i)
    );

    // operand 1 (rs or imm)
    operand_bypass u_byp1 (
        .rd_en_i   (dec.rd1_en),
        .rd_addr_i (dec.rd1_addr),
        .rf_data_i (rf_rd1_data),
        .imm_i     (dec.imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (reg1)
    );

    // operand 2 (rt or imm)
    operand_bypass u_byp2 (
        .rd_en_i   (dec.rd2_en),
        .rd_addr_i (dec.rd2_addr),
        .rf_data_i (rf_rd2_data),
        .imm_i     (dec.imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (reg2)
    );

    // movn/movz only write when the forwarded rt passes the test
    always_comb begin
        case (dec.aluop)
            ALU_MOVN: wreg = dec.wreg & (reg2 != '0);
            ALU_MOVZ: wreg = dec.wreg & (reg2 == '0);
            default:  wreg = dec.wreg;
        endcase
    end

    // ID/EX register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_o.aluop  <= ALU_NOP;
            id_ex_o.alusel <= SEL_NOP;
            id_ex_o.wreg   <= 1'b0;
            id_ex_o.waddr  <= '0;
            id_ex_o.reg1   <= '0;
            id_ex_o.reg2   <= '0;
        end else begin
            id_ex_o.aluop  <= dec.aluop;
            id_ex_o.alusel <= dec.alusel;
            id_ex_o.wreg   <= wreg;
            id_ex_o.waddr  <= dec.waddr;
            id_ex_o.reg1   <= reg1;
            id_ex_o.reg2   <= reg2;
        end
    end

endmodule

/* bench/tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage;
    import id_pkg::*;

    // one line of the vector file
    typedef struct packed {
        logic [31:0] inst;
        bypass_t     ex_fwd;
        bypass_t     mem_fwd;
        bypass_t     wb;
        id_ex_t      exp;
    } vector_t;

    localparam string       VEC_FILE  = "bench/id_vectors.txt";
    localparam logic [31:0] IDLE_INST = 32'hffff_ffff;  // opcode 0x3f, a bubble

    logic        clk;
    logic        arst_n_i;
    logic [31:0] inst_i;
    bypass_t     ex_fwd_i;
    bypass_t     mem_fwd_i;
    bypass_t     wb_i;
    id_ex_t      id_ex_o;

    vector_t vecs[$];
    logic    vecs_loaded;
    int      errors;
    int      checks;
    string   step_tag;  // which vector the current checks belong to

    id_stage dut0 (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .inst_i    (inst_i),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .wb_i      (wb_i),
        .id_ex_o   (id_ex_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [16];
        vector_t     v;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("could not open the vector file %s", VEC_FILE);
            return;
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                        f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
            if (n == 16) begin  // comment lines give no match
                v.inst       = f[0];
                v.ex_fwd     = {f[1][0], f[2][4:0], f[3]};
                v.mem_fwd    = {f[4][0], f[5][4:0], f[6]};
                v.wb         = {f[7][0], f[8][4:0], f[9]};
                v.exp.aluop  = alu_op_e'(f[10][4:0]);
                v.exp.alusel = alu_sel_e'(f[11][2:0]);
                v.exp.wreg   = f[12][0];
                v.exp.waddr  = f[13][4:0];
                v.exp.reg1   = f[14];
                v.exp.reg2   = f[15];
                vecs.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    // called right after a rising edge
    task automatic apply_vector(input vector_t v);
        bypass_t ex;
        bypass_t mem;
        bypass_t wb;
        ex  = v.ex_fwd;
        mem = v.mem_fwd;
        wb  = v.wb;
        // idle bypass data must not matter
        if (!ex.wreg) begin
            ex.wdata = $urandom();
        end
        if (!mem.wreg) begin
            mem.wdata = $urandom();
        end
        if (!wb.wreg) begin
            wb.wdata = $urandom();
        end
        inst_i    <= v.inst;
        ex_fwd_i  <= ex;
        mem_fwd_i <= mem;
        wb_i      <= wb;
    endtask

    task automatic compare_value(input string name, input logic [31:0] act,
                                 input logic [31:0] exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s is 0x%08h, expected 0x%08h (%s, %0t)",
                     name, act, exp, step_tag, $time);
        end
    endtask

    task automatic verify_id_ex(input id_ex_t exp);
        compare_value("id_ex_o.aluop", 32'(id_ex_o.aluop), 32'(exp.aluop));
        compare_value("id_ex_o.alusel", 32'(id_ex_o.alusel), 32'(exp.alusel));
        compare_value("id_ex_o.wreg", 32'(id_ex_o.wreg), 32'(exp.wreg));
        compare_value("id_ex_o.waddr", 32'(id_ex_o.waddr), 32'(exp.waddr));
        compare_value("id_ex_o.reg1", id_ex_o.reg1, exp.reg1);
        compare_value("id_ex_o.reg2", id_ex_o.reg2, exp.reg2);
    endtask

    // one instruction per cycle, result checked at the falling edge after capture
    task automatic run_vectors();
        vector_t idle;
        id_ex_t  reset_state;
        idle        = '0;
        idle.inst   = IDLE_INST;
        reset_state = '0;  // NOP/NOP, no write, zero operands
        repeat (3) @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        step_tag = "after reset";
        verify_id_ex(reset_state);
        for (int i = 0; i < vecs.size(); i++) begin
            @(posedge clk);
            apply_vector(vecs[i]);
            @(negedge clk);
            if (i > 0) begin
                step_tag = $sformatf("vector %0d", i - 1);
                verify_id_ex(vecs[i - 1].exp);
            end
        end
        @(posedge clk);
        apply_vector(idle);
        @(negedge clk);
        step_tag = $sformatf("vector %0d", vecs.size() - 1);
        verify_id_ex(vecs[vecs.size() - 1].exp);
    endtask

    initial begin
        void'($urandom(32'h7b0c));
        arst_n_i    = 1'b0;
        inst_i      = IDLE_INST;
        ex_fwd_i    = '0;
        mem_fwd_i   = '0;
        wb_i        = '0;
        errors      = 0;
        checks      = 0;
        step_tag    = "";
        vecs_loaded = 1'b0;
        load_vectors();
        vecs_loaded = 1'b1;
        if (vecs.size() == 0) begin
            $display("no vectors were read, nothing was tested");
            $display("Simulation failed");
        end else begin
            run_vectors();
            $display("%0d vectors, %0d checks, %0d errors", vecs.size(), checks, errors);
            if (errors == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
        end
        $finish;
    end

    // reset and drain take a few cycles, the rest is one cycle per vector
    initial begin
        wait (vecs_loaded);
        #((vecs.size() + 10) * 10);
        $display("watchdog expired before all vectors were checked");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* sim.f */
+incdir+hw
hw/id_pkg.sv
hw/inst_decoder.sv
hw/operand_bypass.sv
hw/reg_file.sv
hw/id_stage.sv
bench/tb_id_stage.sv

/* run_sim.sh */
#!/bin/sh
# builds the ID stage testbench with Verilator, runs it, looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_id_stage -o sim_id_stage \
    || exit 1

out=$(./obj_dir/sim_id_stage) || exit 1
echo "$out"
echo "$out" | grep -qx "Simulation passed" && exit 0 || exit 1

/* bench/id_vectors.txt */
# inst | ex: wreg waddr wdata | mem: wreg waddr wdata | wb: wreg waddr wdata |
# expected id_ex: aluop alusel wreg waddr reg1 reg2, all hex, wdata random when wreg is 0
0000000f 0 00 0 0 00 0 1 01 12345678 00 0 0 00 00000000 00000000
34238001 0 00 0 0 00 0 1 02 0000ff00 02 1 1 03 12345678 00008001
00222024 0 00 0 0 00 0 1 05 80000000 01 1 1 04 12345678 0000ff00
3046f0f0 0 00 0 0 00 0 0 00 0 01 1 1 06 0000ff00 0000f0f0
38a71234 0 00 0 0 00 0 0 00 0 03 1 1 07 80000000 00001234
3c08abcd 0 00 0 0 00 0 0 00 0 05 1 1 08 00000000 abcd0000
00254827 0 00 0 0 00 0 0 00 0 04 1 1 09 12345678 80000000
00415026 0 00 0 0 00 0 0 00 0 03 1 1 0a 0000ff00 12345678
00a25825 0 00 0 0 00 0 0 00 0 02 1 1 0b 80000000 0000ff00
00226020 0 00 0 0 00 0 0 00 0 09 3 1 0c 12345678 0000ff00
00a16821 0 00 0 0 00 0 0 00 0 0a 3 1 0d 80000000 12345678
00417022 0 00 0 0 00 0 0 00 0 0b 3 1 0e 0000ff00 12345678
00257823 0 00 0 0 00 0 0 00 0 0c 3 1 0f 12345678 80000000
00a2802a 0 00 0 0 00 0 0 00 0 0d 3 1 10 80000000 0000ff00
0045882b 0 00 0 0 00 0 0 00 0 0e 3 1 11 0000ff00 80000000
2032fff0 0 00 0 0 00 0 0 00 0 09 3 1 12 12345678 fffffff0
24537fff 0 00 0 0 00 0 0 00 0 0a 3 1 13 0000ff00 00007fff
28b48000 0 00 0 0 00 0 0 00 0 0d 3 1 14 80000000 ffff8000
2c350001 0 00 0 0 00 0 0 00 0 0e 3 1 15 12345678 00000001
0001b100 0 00 0 0 00 0 0 00 0 06 2 1 16 00000004 12345678
0005bfc2 0 00 0 0 00 0 0 00 0 07 2 1 17 0000001f 80000000
0002c203 0 00 0 0 00 0 0 00 0 08 2 1 18 00000008 0000ff00
0041c804 0 00 0 0 00 0 0 00 0 06 2 1 19 0000ff00 12345678
0025d006 0 00 0 0 00 0 0 00 0 07 2 1 1a 12345678 80000000
00a2d807 0 00 0 0 00 0 0 00 0 08 2 1 1b 80000000 0000ff00
00221820 1 01 aaaa0001 1 01 bbbb0002 0 00 0 09 3 1 03 aaaa0001 0000ff00
00221820 1 07 dddd0004 1 02 cccc0003 0 00 0 09 3 1 03 12345678 cccc0003
00c22025 0 00 0 0 00 0 1 06 0f0f0f0f 02 1 1 04 0f0f0f0f 0000ff00
0026480b 0 00 0 0 00 0 0 00 0 0f 4 1 09 12345678 0f0f0f0f
002a480b 0 00 0 0 00 0 0 00 0 0f 4 0 09 12345678 00000000
002a480a 0 00 0 0 00 0 0 00 0 10 4 1 09 12345678 00000000
002a480a 1 0a 00000001 0 00 0 0 00 0 10 4 0 09 12345678 00000001
00220018 1 01 aaaa0001 0 00 0 0 00 0 00 0 0 00 00000000 00000000
